//--- ctrl_macros.svh
`ifndef CTRL_MACROS_SVH
`define CTRL_MACROS_SVH

// instruction fields
`define OPCODE_W 6
`define FUNCT_W 6

// control unit encodings
`define STATE_W 5
`define CLASS_W 4

// control word fields
`define ALU_OP_W 3
`define SH_OP_W 3
`define M2R_W 3
`define SEL_W 2    // two-bit mux selects

`endif

//--- ctrl_pkg.sv
`include "ctrl_macros.svh"

package ctrl_pkg;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [`FUNCT_W-1:0] {
        FN_SLL = 6'h00,
        FN_SRA = 6'h03,
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_SLT = 6'h2a
    } funct_t;

    typedef enum logic [`CLASS_W-1:0] {
        CLS_ALU_R, CLS_SLT, CLS_SHIFT, CLS_JR, CLS_J, CLS_ADDI,
        CLS_BEQ, CLS_BNE, CLS_LUI, CLS_LW, CLS_SW, CLS_ILLEGAL
    } instr_class_t;

    // contiguous encoding, ST_MEM_WRITE is the highest
    typedef enum logic [`STATE_W-1:0] {
        ST_RESET, ST_FETCH, ST_DECODE_WAIT, ST_DECODE,
        ST_ALU_EXEC, ST_ALU_WRITEBACK, ST_SLT_WRITE,
        ST_SHIFT_EXEC, ST_SHIFT_WRITEBACK,
        ST_JUMP_REG, ST_JUMP,
        ST_IMM_EXEC, ST_IMM_WRITEBACK,
        ST_BRANCH, ST_LUI_WRITEBACK,
        ST_ADDR_CALC, ST_MEM_READ, ST_LOAD_WRITEBACK, ST_MEM_WRITE
    } state_t;

    typedef enum logic [`ALU_OP_W-1:0] {
        ALU_ADD  = 3'd0,
        ALU_PLUS = 3'd1,    // pc and address adder
        ALU_SUB  = 3'd2,
        ALU_AND  = 3'd3
    } alu_op_t;

    typedef enum logic [`SH_OP_W-1:0] {
        SH_NONE = 3'd0,
        SH_SLL  = 3'd2,
        SH_SRA  = 3'd4
    } shift_op_t;

    typedef enum logic [`SEL_W-1:0] {
        IOD_PC      = 2'd0,
        IOD_ALU_OUT = 2'd3
    } i_or_d_t;

    typedef enum logic [`M2R_W-1:0] {
        M2R_SHIFT   = 3'd0,
        M2R_MEM     = 3'd2,
        M2R_LESS    = 3'd3,
        M2R_ALU_OUT = 3'd5,
        M2R_LUI     = 3'd6
    } mem_to_reg_t;

    typedef enum logic [`SEL_W-1:0] {PC_ALU, PC_ALU_OUT, PC_JUMP, PC_REG_A} pc_src_t;
    typedef enum logic [`SEL_W-1:0] {SA_PC, SA_REG_A} alu_src_a_t;
    typedef enum logic [`SEL_W-1:0] {SB_REG_B, SB_FOUR, SB_IMM, SB_IMM_SHIFTED} alu_src_b_t;
    typedef enum logic [`SEL_W-1:0] {RD_RT, RD_RD} reg_dst_t;

endpackage

//--- instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  ctrl_pkg::opcode_t      i_opcode,
    input  ctrl_pkg::funct_t       i_funct,
    output ctrl_pkg::instr_class_t o_class,
    output ctrl_pkg::alu_op_t      o_alu_op,
    output ctrl_pkg::shift_op_t    o_shift_op
);

    import ctrl_pkg::*;

    // instruction class
    always_comb begin
        case (i_opcode)
            OP_RTYPE: begin
                case (i_funct)
                    FN_ADD, FN_SUB, FN_AND: o_class = CLS_ALU_R;
                    FN_SLT:                 o_class = CLS_SLT;
                    FN_SLL, FN_SRA:         o_class = CLS_SHIFT;
                    FN_JR:                  o_class = CLS_JR;
                    default:                o_class = CLS_ILLEGAL;
                endcase
            end
            OP_J:    o_class = CLS_J;
            OP_ADDI: o_class = CLS_ADDI;
            OP_BEQ:  o_class = CLS_BEQ;
            OP_BNE:  o_class = CLS_BNE;
            OP_LUI:  o_class = CLS_LUI;
            OP_LW:   o_class = CLS_LW;
            OP_SW:   o_class = CLS_SW;
            default: o_class = CLS_ILLEGAL;    // unknown opcode
        endcase
    end

    // r-type alu operation
    always_comb begin
        case (i_funct)
            FN_SUB:  o_alu_op = ALU_SUB;
            FN_AND:  o_alu_op = ALU_AND;
            default: o_alu_op = ALU_ADD;
        endcase
    end

    // shifter operation
    always_comb begin
        case (i_funct)
            FN_SLL:  o_shift_op = SH_SLL;
            FN_SRA:  o_shift_op = SH_SRA;
            default: o_shift_op = SH_NONE;
        endcase
    end

endmodule

//--- state_sequencer.sv
`timescale 1ns/100ps

module state_sequencer (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_pkg::instr_class_t i_class,
    output ctrl_pkg::state_t       o_state
);

    import ctrl_pkg::*;

    state_t state;
    state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ST_RESET:       next_state = ST_FETCH;
            ST_FETCH:       next_state = ST_DECODE_WAIT;
            ST_DECODE_WAIT: next_state = ST_DECODE;
            ST_DECODE: begin
                case (i_class)
                    CLS_ALU_R:        next_state = ST_ALU_EXEC;
                    CLS_SLT:          next_state = ST_SLT_WRITE;
                    CLS_SHIFT:        next_state = ST_SHIFT_EXEC;
                    CLS_JR:           next_state = ST_JUMP_REG;
                    CLS_J:            next_state = ST_JUMP;
                    CLS_ADDI:         next_state = ST_IMM_EXEC;
                    CLS_BEQ, CLS_BNE: next_state = ST_BRANCH;
                    CLS_LUI:          next_state = ST_LUI_WRITEBACK;
                    CLS_LW, CLS_SW:   next_state = ST_ADDR_CALC;
                    default:          next_state = ST_FETCH;    // illegal, skip it
                endcase
            end
            ST_ALU_EXEC:   next_state = ST_ALU_WRITEBACK;
            ST_SHIFT_EXEC: next_state = ST_SHIFT_WRITEBACK;
            ST_IMM_EXEC:   next_state = ST_IMM_WRITEBACK;
            // class still valid here, opcode held until next fetch
            ST_ADDR_CALC:  next_state = (i_class == CLS_SW) ? ST_MEM_WRITE : ST_MEM_READ;
            ST_MEM_READ:   next_state = ST_LOAD_WRITEBACK;
            default:       next_state = ST_FETCH;    // last execute state
        endcase
    end

    assign o_state = state;

    // encoding is contiguous up to ST_MEM_WRITE
    a_state_named: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(o_state) && (o_state <= ST_MEM_WRITE)
    ) else $error("state_sequencer: illegal state %0h", o_state);

    a_fetch_then_wait: assert property (
        @(posedge clk) disable iff (reset)
        (o_state == ST_FETCH) |=> (o_state == ST_DECODE_WAIT)
    ) else $error("state_sequencer: fetch not followed by decode wait");

    a_reset_exit: assert property (
        @(posedge clk)
        (o_state == ST_RESET) && !reset |=> (o_state == ST_FETCH)
    ) else $error("state_sequencer: reset left for %0h", o_state);

endmodule

//--- control_encoder.sv
`timescale 1ns/100ps

module control_encoder (
    input  ctrl_pkg::state_t       i_state,
    input  ctrl_pkg::instr_class_t i_class,
    input  ctrl_pkg::alu_op_t      i_alu_op,
    input  ctrl_pkg::shift_op_t    i_shift_op,
    input  logic                   i_eq,
    output logic                   o_pc_write,
    output logic                   o_mem_read,
    output logic                   o_mem_write,
    output logic                   o_ir_write,
    output logic                   o_reg_write,
    output ctrl_pkg::i_or_d_t      o_i_or_d,
    output ctrl_pkg::mem_to_reg_t  o_mem_to_reg,
    output ctrl_pkg::pc_src_t      o_pc_src,
    output ctrl_pkg::alu_op_t      o_alu_op,
    output ctrl_pkg::alu_src_a_t   o_alu_src_a,
    output ctrl_pkg::alu_src_b_t   o_alu_src_b,
    output ctrl_pkg::reg_dst_t     o_reg_dst,
    output ctrl_pkg::shift_op_t    o_sh_op
);

    import ctrl_pkg::*;

    logic branch_taken;

    // beq on equal, bne on not equal
    always_comb begin
        case (i_class)
            CLS_BEQ: branch_taken = i_eq;
            CLS_BNE: branch_taken = !i_eq;
            default: branch_taken = 1'b0;
        endcase
    end

    always_comb begin
        o_pc_write   = 1'b0;
        o_mem_read   = 1'b0;
        o_mem_write  = 1'b0;
        o_ir_write   = 1'b0;
        o_reg_write  = 1'b0;
        o_i_or_d     = IOD_PC;
        o_mem_to_reg = M2R_SHIFT;
        o_pc_src     = PC_ALU;
        o_alu_op     = ALU_ADD;
        o_alu_src_a  = SA_PC;
        o_alu_src_b  = SB_REG_B;
        o_reg_dst    = RD_RT;
        o_sh_op      = SH_NONE;

        case (i_state)
            ST_RESET: begin
                o_pc_write = 1'b1;
            end
            ST_FETCH: begin
                o_mem_read  = 1'b1;
                o_ir_write  = 1'b1;
                o_pc_write  = 1'b1;    // pc + 4
                o_alu_op    = ALU_PLUS;
                o_alu_src_b = SB_FOUR;
            end
            ST_DECODE_WAIT: begin
                o_alu_op    = ALU_PLUS;    // branch target ahead of time
                o_alu_src_b = SB_IMM_SHIFTED;
            end
            ST_ALU_EXEC: begin
                o_alu_op    = i_alu_op;
                o_alu_src_a = SA_REG_A;
            end
            ST_ALU_WRITEBACK: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = M2R_ALU_OUT;
                o_reg_dst    = RD_RD;
            end
            ST_SLT_WRITE: begin
                o_reg_write  = 1'b1;
                o_alu_op     = ALU_SUB;    // less flag from a - b
                o_alu_src_a  = SA_REG_A;
                o_mem_to_reg = M2R_LESS;
                o_reg_dst    = RD_RD;
            end
            ST_SHIFT_EXEC: begin
                o_sh_op = i_shift_op;
            end
            ST_SHIFT_WRITEBACK: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = M2R_SHIFT;
                o_reg_dst    = RD_RD;
            end
            ST_JUMP_REG: begin
                o_pc_write = 1'b1;
                o_pc_src   = PC_REG_A;
            end
            ST_JUMP: begin
                o_pc_write = 1'b1;
                o_pc_src   = PC_JUMP;
            end
            ST_IMM_EXEC, ST_ADDR_CALC: begin
                o_alu_op    = ALU_PLUS;
                o_alu_src_a = SA_REG_A;
                o_alu_src_b = SB_IMM;
            end
            ST_IMM_WRITEBACK: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = M2R_ALU_OUT;
            end
            ST_BRANCH: begin
                o_alu_op    = ALU_SUB;
                o_alu_src_a = SA_REG_A;
                o_pc_src    = PC_ALU_OUT;    // target from decode wait
                o_pc_write  = branch_taken;
            end
            ST_LUI_WRITEBACK: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = M2R_LUI;
            end
            ST_MEM_READ: begin
                o_mem_read = 1'b1;
                o_i_or_d   = IOD_ALU_OUT;
            end
            ST_LOAD_WRITEBACK: begin
                o_reg_write  = 1'b1;
                o_mem_to_reg = M2R_MEM;
            end
            ST_MEM_WRITE: begin
                o_mem_write = 1'b1;
                o_i_or_d    = IOD_ALU_OUT;
            end
            default: ;    // decode, nothing active
        endcase
    end

    // checked on every state change
    a_mem_exclusive: assert property (
        @(i_state) !(o_mem_read && o_mem_write)
    ) else $error("control_encoder: mem_read and mem_write both high");

endmodule

//--- mips_control_unit.sv
`timescale 1ns/100ps

`include "ctrl_macros.svh"

module mips_control_unit (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`OPCODE_W-1:0]    i_opcode,
    input  logic [`FUNCT_W-1:0]     i_funct,
    input  logic                    i_eq,    // a == b from the alu
    output ctrl_pkg::state_t        o_state,
    output logic                    o_pc_write,
    output logic                    o_mem_read,
    output logic                    o_mem_write,
    output logic                    o_ir_write,
    output logic                    o_reg_write,
    output ctrl_pkg::i_or_d_t       o_i_or_d,
    output ctrl_pkg::mem_to_reg_t   o_mem_to_reg,
    output ctrl_pkg::pc_src_t       o_pc_src,
    output ctrl_pkg::alu_op_t       o_alu_op,
    output ctrl_pkg::alu_src_a_t    o_alu_src_a,
    output ctrl_pkg::alu_src_b_t    o_alu_src_b,
    output ctrl_pkg::reg_dst_t      o_reg_dst,
    output ctrl_pkg::shift_op_t     o_sh_op
);

    import ctrl_pkg::*;

    instr_class_t instr_class;
    alu_op_t      rtype_alu_op;
    shift_op_t    shift_op;

    instr_decoder u_decoder (
        .i_opcode   (opcode_t'(i_opcode)),    // raw ir fields, may be unknown codes
        .i_funct    (funct_t'(i_funct)),
        .o_class    (instr_class),
        .o_alu_op   (rtype_alu_op),
        .o_shift_op (shift_op)
    );

    state_sequencer u_sequencer (
        .clk     (clk),
        .reset   (reset),
        .i_class (instr_class),
        .o_state (o_state)
    );

    control_encoder u_encoder (
        .i_state      (o_state),
        .i_class      (instr_class),
        .i_alu_op     (rtype_alu_op),
        .i_shift_op   (shift_op),
        .i_eq         (i_eq),
        .o_pc_write   (o_pc_write),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_ir_write   (o_ir_write),
        .o_reg_write  (o_reg_write),
        .o_i_or_d     (o_i_or_d),
        .o_mem_to_reg (o_mem_to_reg),
        .o_pc_src     (o_pc_src),
        .o_alu_op     (o_alu_op),
        .o_alu_src_a  (o_alu_src_a),
        .o_alu_src_b  (o_alu_src_b),
        .o_reg_dst    (o_reg_dst),
        .o_sh_op      (o_sh_op)
    );

endmodule

//--- tb_control_model.svh
`ifndef TB_CONTROL_MODEL_SVH
`define TB_CONTROL_MODEL_SVH

// flags are pc_write, mem_read, mem_write, ir_write, reg_write from the top bit down
typedef struct packed {
    logic [4:0]  flags;
    i_or_d_t     i_or_d;
    mem_to_reg_t mem_to_reg;
    pc_src_t     pc_src;
    alu_op_t     alu_op;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    reg_dst_t    reg_dst;
    shift_op_t   sh_op;
} ctrl_word_t;

function automatic state_t exec_state(input instr_class_t cls, input int idx);
    state_t seq [3];
    case (cls)
        CLS_ALU_R:        seq = '{ST_ALU_EXEC, ST_ALU_WRITEBACK, ST_FETCH};
        CLS_SHIFT:        seq = '{ST_SHIFT_EXEC, ST_SHIFT_WRITEBACK, ST_FETCH};
        CLS_ADDI:         seq = '{ST_IMM_EXEC, ST_IMM_WRITEBACK, ST_FETCH};
        CLS_LW:           seq = '{ST_ADDR_CALC, ST_MEM_READ, ST_LOAD_WRITEBACK};
        CLS_SW:           seq = '{ST_ADDR_CALC, ST_MEM_WRITE, ST_FETCH};
        CLS_SLT:          seq = '{ST_SLT_WRITE, ST_FETCH, ST_FETCH};
        CLS_JR:           seq = '{ST_JUMP_REG, ST_FETCH, ST_FETCH};
        CLS_J:            seq = '{ST_JUMP, ST_FETCH, ST_FETCH};
        CLS_BEQ, CLS_BNE: seq = '{ST_BRANCH, ST_FETCH, ST_FETCH};
        CLS_LUI:          seq = '{ST_LUI_WRITEBACK, ST_FETCH, ST_FETCH};
        default:          seq = '{ST_FETCH, ST_FETCH, ST_FETCH};    // illegal goes straight back
    endcase
    return (idx < 3) ? seq[idx] : ST_FETCH;
endfunction

function automatic ctrl_word_t expected_word(input state_t st, input instr_class_t cls,
                                             input alu_op_t rtype_op, input shift_op_t sh_op,
                                             input logic eq);
    ctrl_word_t w;
    w = '0;
    case (st)
        ST_RESET:
            w.flags = 5'b10000;
        ST_FETCH:
            w = '{5'b11010, IOD_PC, M2R_SHIFT, PC_ALU, ALU_PLUS, SA_PC, SB_FOUR, RD_RT, SH_NONE};
        ST_DECODE_WAIT:
            w = '{5'b00000, IOD_PC, M2R_SHIFT, PC_ALU, ALU_PLUS, SA_PC, SB_IMM_SHIFTED,
                  RD_RT, SH_NONE};
        ST_ALU_EXEC:
            w = '{5'b00000, IOD_PC, M2R_SHIFT, PC_ALU, rtype_op, SA_REG_A, SB_REG_B, RD_RT, SH_NONE};
        ST_ALU_WRITEBACK:
            w = '{5'b00001, IOD_PC, M2R_ALU_OUT, PC_ALU, ALU_ADD, SA_PC, SB_REG_B, RD_RD, SH_NONE};
        ST_SLT_WRITE:
            w = '{5'b00001, IOD_PC, M2R_LESS, PC_ALU, ALU_SUB, SA_REG_A, SB_REG_B, RD_RD, SH_NONE};
        ST_SHIFT_EXEC:
            w.sh_op = sh_op;
        ST_SHIFT_WRITEBACK:
            w = '{5'b00001, IOD_PC, M2R_SHIFT, PC_ALU, ALU_ADD, SA_PC, SB_REG_B, RD_RD, SH_NONE};
        ST_JUMP_REG:
            w = '{5'b10000, IOD_PC, M2R_SHIFT, PC_REG_A, ALU_ADD, SA_PC, SB_REG_B, RD_RT, SH_NONE};
        ST_JUMP:
            w = '{5'b10000, IOD_PC, M2R_SHIFT, PC_JUMP, ALU_ADD, SA_PC, SB_REG_B, RD_RT, SH_NONE};
        ST_IMM_EXEC, ST_ADDR_CALC:
            w = '{5'b00000, IOD_PC, M2R_SHIFT, PC_ALU, ALU_PLUS, SA_REG_A, SB_IMM, RD_RT, SH_NONE};
        ST_IMM_WRITEBACK:
            w = '{5'b00001, IOD_PC, M2R_ALU_OUT, PC_ALU, ALU_ADD, SA_PC, SB_REG_B, RD_RT, SH_NONE};
        ST_BRANCH:
            w = '{5'b00000, IOD_PC, M2R_SHIFT, PC_ALU_OUT, ALU_SUB, SA_REG_A, SB_REG_B,
                  RD_RT, SH_NONE};
        ST_LUI_WRITEBACK:
            w = '{5'b00001, IOD_PC, M2R_LUI, PC_ALU, ALU_ADD, SA_PC, SB_REG_B, RD_RT, SH_NONE};
        ST_MEM_READ:
            w = '{5'b01000, IOD_ALU_OUT, M2R_SHIFT, PC_ALU, ALU_ADD, SA_PC, SB_REG_B, RD_RT, SH_NONE};
        ST_LOAD_WRITEBACK:
            w = '{5'b00001, IOD_PC, M2R_MEM, PC_ALU, ALU_ADD, SA_PC, SB_REG_B, RD_RT, SH_NONE};
        ST_MEM_WRITE:
            w = '{5'b00100, IOD_ALU_OUT, M2R_SHIFT, PC_ALU, ALU_ADD, SA_PC, SB_REG_B, RD_RT, SH_NONE};
        default: ;    // decode, all inactive
    endcase
    // branch taken rule
    if (st == ST_BRANCH) begin
        w.flags[4] = (cls == CLS_BEQ && eq) || (cls == CLS_BNE && !eq);
    end
    return w;
endfunction

`endif

//--- tb_control_unit.sv
`timescale 1ns/100ps

`include "ctrl_macros.svh"

module tb_control_unit;

    import ctrl_pkg::*;

    `include "tb_control_model.svh"

    logic                 clk;
    logic                 reset;
    logic [`OPCODE_W-1:0] i_opcode;
    logic [`FUNCT_W-1:0]  i_funct;
    logic                 i_eq;
    state_t               o_state;
    logic                 o_pc_write, o_mem_read, o_mem_write, o_ir_write, o_reg_write;
    i_or_d_t              o_i_or_d;
    mem_to_reg_t          o_mem_to_reg;
    pc_src_t              o_pc_src;
    alu_op_t              o_alu_op;
    alu_src_a_t           o_alu_src_a;
    alu_src_b_t           o_alu_src_b;
    reg_dst_t             o_reg_dst;
    shift_op_t            o_sh_op;

    state_t       exp_state;
    instr_class_t exp_class;
    alu_op_t      exp_alu_op;
    shift_op_t    exp_sh_op;
    int           exec_idx;
    logic         check_en;
    int           errors;
    int           tests;
    int           failed_tests;
    ctrl_word_t   act_word;
    ctrl_word_t   exp_word;

    mips_control_unit UUT (
        .clk          (clk),
        .reset        (reset),
        .i_opcode     (i_opcode),
        .i_funct      (i_funct),
        .i_eq         (i_eq),
        .o_state      (o_state),
        .o_pc_write   (o_pc_write),
        .o_mem_read   (o_mem_read),
        .o_mem_write  (o_mem_write),
        .o_ir_write   (o_ir_write),
        .o_reg_write  (o_reg_write),
        .o_i_or_d     (o_i_or_d),
        .o_mem_to_reg (o_mem_to_reg),
        .o_pc_src     (o_pc_src),
        .o_alu_op     (o_alu_op),
        .o_alu_src_a  (o_alu_src_a),
        .o_alu_src_b  (o_alu_src_b),
        .o_reg_dst    (o_reg_dst),
        .o_sh_op      (o_sh_op)
    );

    assign act_word = '{{o_pc_write, o_mem_read, o_mem_write, o_ir_write, o_reg_write},
                        o_i_or_d, o_mem_to_reg, o_pc_src, o_alu_op, o_alu_src_a,
                        o_alu_src_b, o_reg_dst, o_sh_op};
    assign exp_word = expected_word(exp_state, exp_class, exp_alu_op, exp_sh_op, i_eq);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reference state walk
    always @(posedge clk) begin
        check_en <= 1'b1;
        if (reset) begin
            exp_state <= ST_RESET;
        end else begin
            case (exp_state)
                ST_RESET:       exp_state <= ST_FETCH;
                ST_FETCH:       exp_state <= ST_DECODE_WAIT;
                ST_DECODE_WAIT: exp_state <= ST_DECODE;
                ST_DECODE: begin
                    exp_state <= exec_state(exp_class, 0);
                    exec_idx  <= 1;
                end
                default: begin
                    exp_state <= exec_state(exp_class, exec_idx);
                    exec_idx  <= exec_idx + 1;
                end
            endcase
        end
    end

    a_state: assert property (@(posedge clk) check_en |-> (o_state == exp_state))
        else report_mismatch("o_state", $sampled(o_state), $sampled(exp_state));

    a_word: assert property (@(posedge clk) check_en |-> (act_word == exp_word))
        else report_word_mismatch($sampled(act_word), $sampled(exp_word));

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("Error: %s is %0h, expected %0h at %0t", name, got, want, $time);
        errors++;
    endtask

    task automatic report_word_mismatch(input ctrl_word_t got, input ctrl_word_t want);
        string flag_name [5];
        flag_name = '{"o_pc_write", "o_mem_read", "o_mem_write", "o_ir_write", "o_reg_write"};
        for (int b = 0; b < 5; b++) begin
            if (got.flags[4-b] !== want.flags[4-b])
                report_mismatch(flag_name[b], got.flags[4-b], want.flags[4-b]);
        end
        if (got.i_or_d !== want.i_or_d)
            report_mismatch("o_i_or_d", got.i_or_d, want.i_or_d);
        if (got.mem_to_reg !== want.mem_to_reg)
            report_mismatch("o_mem_to_reg", got.mem_to_reg, want.mem_to_reg);
        if (got.pc_src !== want.pc_src)
            report_mismatch("o_pc_src", got.pc_src, want.pc_src);
        if (got.alu_op !== want.alu_op)
            report_mismatch("o_alu_op", got.alu_op, want.alu_op);
        if (got.alu_src_a !== want.alu_src_a)
            report_mismatch("o_alu_src_a", got.alu_src_a, want.alu_src_a);
        if (got.alu_src_b !== want.alu_src_b)
            report_mismatch("o_alu_src_b", got.alu_src_b, want.alu_src_b);
        if (got.reg_dst !== want.reg_dst)
            report_mismatch("o_reg_dst", got.reg_dst, want.reg_dst);
        if (got.sh_op !== want.sh_op)
            report_mismatch("o_sh_op", got.sh_op, want.sh_op);
    endtask

    // returns on the edge that closes a fetch cycle
    task automatic wait_for_fetch();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (o_state != ST_FETCH && n < 10);
        if (o_state != ST_FETCH) begin
            $display("timeout: no fetch state within 10 cycles at %0t", $time);
            $display("TB FAILED");
            $finish;
        end
    endtask

    task automatic run_instr(input string name, input logic [5:0] op, input logic [5:0] fn,
                             input instr_class_t cls, input alu_op_t alu,
                             input shift_op_t sh, input logic eq);
        int err_before;
        err_before = errors;
        i_opcode   <= op;
        i_funct    <= fn;
        i_eq       <= eq;
        exp_class  <= cls;
        exp_alu_op <= alu;
        exp_sh_op  <= sh;
        wait_for_fetch();
        tests++;
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("%-16s eq=%0d %s", name, eq, (errors == err_before) ? "ok" : "mismatch");
    endtask

    task automatic run_by_index(input int k, input logic eq);
        case (k)
            0:  run_instr("add", OP_RTYPE, FN_ADD, CLS_ALU_R, ALU_ADD, SH_NONE, eq);
            1:  run_instr("sub", OP_RTYPE, FN_SUB, CLS_ALU_R, ALU_SUB, SH_NONE, eq);
            2:  run_instr("and", OP_RTYPE, FN_AND, CLS_ALU_R, ALU_AND, SH_NONE, eq);
            3:  run_instr("slt", OP_RTYPE, FN_SLT, CLS_SLT, ALU_ADD, SH_NONE, eq);
            4:  run_instr("sll", OP_RTYPE, FN_SLL, CLS_SHIFT, ALU_ADD, SH_SLL, eq);
            5:  run_instr("sra", OP_RTYPE, FN_SRA, CLS_SHIFT, ALU_ADD, SH_SRA, eq);
            6:  run_instr("jr", OP_RTYPE, FN_JR, CLS_JR, ALU_ADD, SH_NONE, eq);
            7:  run_instr("j", OP_J, FN_SLL, CLS_J, ALU_ADD, SH_NONE, eq);
            8:  run_instr("addi", OP_ADDI, FN_SLL, CLS_ADDI, ALU_ADD, SH_NONE, eq);
            9:  run_instr("beq", OP_BEQ, FN_SLL, CLS_BEQ, ALU_ADD, SH_NONE, eq);
            10: run_instr("bne", OP_BNE, FN_SLL, CLS_BNE, ALU_ADD, SH_NONE, eq);
            11: run_instr("lui", OP_LUI, FN_SLL, CLS_LUI, ALU_ADD, SH_NONE, eq);
            12: run_instr("lw", OP_LW, FN_SLL, CLS_LW, ALU_ADD, SH_NONE, eq);
            13: run_instr("sw", OP_SW, FN_SLL, CLS_SW, ALU_ADD, SH_NONE, eq);
            14: run_instr("illegal opcode", 6'h3f, FN_ADD, CLS_ILLEGAL, ALU_ADD, SH_NONE, eq);
            15: run_instr("illegal funct", OP_RTYPE, 6'h3f, CLS_ILLEGAL, ALU_ADD, SH_NONE, eq);
            default: ;
        endcase
    endtask

    initial begin
        int order [16];
        int pick;
        int tmp;
        void'($urandom(86586));
        reset      = 1'b1;
        i_opcode   = OP_RTYPE;
        i_funct    = FN_SLL;
        i_eq       = 1'b0;
        exp_state  = ST_RESET;
        exp_class  = CLS_ILLEGAL;
        exp_alu_op = ALU_ADD;
        exp_sh_op  = SH_NONE;
        exec_idx   = 0;
        check_en   = 1'b0;
        errors     = 0;
        tests      = 0;
        failed_tests = 0;

        repeat (4) @(posedge clk);
        reset <= 1'b0;
        wait_for_fetch();
        tests++;
        if (errors != 0) begin
            failed_tests++;
        end
        $display("%-16s %s", "reset", (errors == 0) ? "ok" : "mismatch");

        // three shuffled rounds, branches see fresh i_eq each time
        for (int round = 0; round < 3; round++) begin
            for (int k = 0; k < 16; k++) begin
                order[k] = k;
            end
            for (int k = 15; k > 0; k--) begin
                pick = $urandom % (k + 1);
                tmp = order[k];
                order[k] = order[pick];
                order[pick] = tmp;
            end
            for (int k = 0; k < 16; k++) begin
                run_by_index(order[k], $urandom % 2);
            end
        end

        // both outcomes of beq and bne
        for (int e = 0; e < 2; e++) begin
            run_by_index(9, e[0]);
            run_by_index(10, e[0]);
        end

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
ctrl_pkg.sv
instr_decoder.sv
state_sequencer.sv
control_encoder.sv
mips_control_unit.sv
tb_control_unit.sv

//--- Bender.yml
package:
  name: mips_control_unit

export_include_dirs:
  - .

sources:
  - ctrl_pkg.sv
  - instr_decoder.sv
  - state_sequencer.sv
  - control_encoder.sv
  - mips_control_unit.sv
  - target: simulation
    files:
      - tb_control_unit.sv
